// File: nes_loader_pkg.sv
/* NES loader shared definitions */
`default_nettype none

package nes_loader_pkg;

  localparam int ines_hdr_len   = 16;  // iNES header bytes
  localparam int prg_page_shift = 14;  // 16 KiB PRG pages
  localparam int chr_page_shift = 13;  // 8 KiB CHR pages

  // "NES" then 1A hex, byte 0 in the top lane
  localparam logic [31:0] ines_magic = 32'h4E45_531A;

  // Mapper flags word as seen by the console core
  typedef struct packed {
    logic [14:0] reserved;
    logic        four_screen;
    logic        has_chr_ram;
    logic        mirroring;
    logic [2:0]  chr_size;     // log2 of CHR pages, capped
    logic [2:0]  prg_size;     // log2 of PRG pages, capped
    logic [7:0]  mapper;
  } mapper_flags_t;

  // Decoded header, parser to loader
  typedef struct packed {
    logic [7:0]    prg_pages;
    logic [7:0]    chr_pages;
    logic          hdr_ok;     // Magic good, no trainer
    mapper_flags_t flags;
  } hdr_info_t;

  typedef enum logic [1:0] {st_header, st_prg, st_chr, st_finish} load_state_e;

  // Host register map, word addresses
  localparam logic [1:0] reg_ctrl   = 2'd0;
  localparam logic [1:0] reg_status = 2'd1;
  localparam logic [1:0] reg_flags  = 2'd2;

  localparam int ctrl_invert_bit  = 0;
  localparam int ctrl_restart_bit = 1;

  localparam int stat_done_bit  = 0;
  localparam int stat_error_bit = 1;
  localparam int stat_busy_bit  = 2;

endpackage

`default_nettype wire

// File: load_req_if.sv
/* Byte write request channel */
`timescale 1ns/1ps
`default_nettype none

interface load_req_if #(parameter int ADDR_W = 22);
  logic              valid;  // Request pending
  logic              ready;  // Writer idle
  logic [ADDR_W-1:0] addr;
  logic [7:0]        data;

  // Loader holds valid, addr, data until valid && ready
  modport loader (output valid, output addr, output data, input ready);
  modport writer (input valid, input addr, input data, output ready);
endinterface

`default_nettype wire

// File: ines_header_parser.sv
/* iNES header capture and decode */
`timescale 1ns/1ps
`default_nettype none

module ines_header_parser import nes_loader_pkg::*; (
  input  logic       clk,
  input  logic       reset_nes,
  input  logic       restart,
  input  logic [7:0] in_data,
  input  logic       take,
  output logic       hdr_done,
  output hdr_info_t  hdr
);

  logic [7:0] hdr_mem [ines_hdr_len];  // Raw header bytes
  logic [3:0] idx;                     // Next slot to fill
  logic       is_nes20;
  logic       is_dirty;

  // Smallest n with pages <= 2**n, saturates at 7
  function automatic logic [2:0] size_code(input logic [7:0] pages);
    logic [2:0] code;
    code = 3'd7;
    for (int n = 6; n >= 0; n--) begin
      if (pages <= (8'd1 << n)) code = 3'(n);
    end
    return code;
  endfunction

  always_ff @(posedge clk) begin
    if (reset_nes || restart) begin
      idx <= '0;
    end else if (take) begin
      idx <= idx + 4'd1;  // Wraps back to 0 after byte 15
    end
  end

  always_ff @(posedge clk) begin
    if (take) hdr_mem[idx] <= in_data;
  end

  // Pulse on the edge that captures the last byte
  assign hdr_done = take && (idx == 4'(ines_hdr_len - 1));

  assign is_nes20 = (hdr_mem[7][3:2] == 2'b10);

  // Old dumpers left junk in bytes 8..15
  always_comb begin
    is_dirty = 1'b0;
    for (int i = 8; i < ines_hdr_len; i++) begin
      is_dirty |= (hdr_mem[i] != 8'h00);
    end
    is_dirty &= !is_nes20;
  end

  always_comb begin
    hdr                   = '0;
    hdr.prg_pages         = hdr_mem[4];
    hdr.chr_pages         = hdr_mem[5];
    // Magic bytes 0..3, trainer flag must be clear
    hdr.hdr_ok            = ({hdr_mem[0], hdr_mem[1], hdr_mem[2], hdr_mem[3]} == ines_magic)
                            && !hdr_mem[6][2];
    hdr.flags.four_screen = hdr_mem[6][3];
    hdr.flags.mirroring   = hdr_mem[6][0];
    hdr.flags.chr_size    = size_code(hdr_mem[5]);
    hdr.flags.prg_size    = size_code(hdr_mem[4]);
    hdr.flags.mapper      = {is_dirty ? 4'h0 : hdr_mem[7][7:4], hdr_mem[6][7:4]};
  end

endmodule

`default_nettype wire

// File: rom_loader.sv
/* ROM image load sequencer */
`timescale 1ns/1ps
`default_nettype none

module rom_loader import nes_loader_pkg::*; #(
  parameter int ADDR_W = 22
) (
  input  logic          clk,
  input  logic          reset_nes,
  input  logic          restart,
  input  logic [7:0]    in_data,
  input  logic          in_valid,
  output logic          in_ready,
  load_req_if.loader    req,
  output logic          load_done,
  output logic          load_error,
  output logic          busy,
  output mapper_flags_t flags
);

  localparam int cnt_w = 8 + prg_page_shift;  // Largest PRG region in bytes
  localparam logic [ADDR_W-1:0] chr_base = {1'b1, {(ADDR_W-1){1'b0}}};

  load_state_e       state;
  logic [cnt_w-1:0]  bytes_left;
  logic [ADDR_W-1:0] addr_q;   // Running memory address
  logic              take;     // Header byte accepted
  logic              xfer;     // Payload byte accepted
  logic              hdr_done;
  hdr_info_t         hdr;
  logic [cnt_w-1:0]  chr_bytes;

  ines_header_parser u_parser (
    .clk       (clk),
    .reset_nes (reset_nes),
    .restart   (restart),
    .in_data   (in_data),
    .take      (take),
    .hdr_done  (hdr_done),
    .hdr       (hdr)
  );

  assign take      = in_valid && (state == st_header);
  assign in_ready  = (state == st_header) ? 1'b1 :
                     (state == st_prg || state == st_chr) ? req.ready : 1'b0;
  assign req.valid = in_valid && (state == st_prg || state == st_chr);
  assign req.addr  = addr_q;
  assign req.data  = in_data;  // Stream byte goes straight to the writer
  assign xfer      = req.valid && req.ready;
  assign chr_bytes = cnt_w'(hdr.chr_pages) << chr_page_shift;
  assign busy      = (state == st_prg) || (state == st_chr) || (state == st_finish && !load_done);

  always_comb begin
    flags             = hdr.flags;
    flags.has_chr_ram = (hdr.chr_pages == 8'd0);  // No CHR ROM means CHR RAM
  end

  always_ff @(posedge clk) begin
    if (reset_nes || restart) begin
      state      <= st_header;
      bytes_left <= '0;
      addr_q     <= '0;
      load_done  <= 1'b0;
      load_error <= 1'b0;
    end else begin
      case (state)
        st_header: if (hdr_done) begin
          if (!hdr.hdr_ok) begin
            state      <= st_finish;
            load_error <= 1'b1;
          end else if (hdr.prg_pages != 8'd0) begin
            state      <= st_prg;
            bytes_left <= cnt_w'(hdr.prg_pages) << prg_page_shift;
          end else if (hdr.chr_pages != 8'd0) begin
            state      <= st_chr;  // PRG region skipped
            addr_q     <= chr_base;
            bytes_left <= chr_bytes;
          end else begin
            state <= st_finish;
          end
        end
        st_prg: if (xfer) begin
          addr_q     <= addr_q + 1'b1;
          bytes_left <= bytes_left - 1'b1;
          if (bytes_left == cnt_w'(1)) begin  // Last PRG byte
            if (hdr.chr_pages != 8'd0) begin
              state      <= st_chr;
              addr_q     <= chr_base;
              bytes_left <= chr_bytes;
            end else begin
              state <= st_finish;
            end
          end
        end
        st_chr: if (xfer) begin
          addr_q     <= addr_q + 1'b1;
          bytes_left <= bytes_left - 1'b1;
          if (bytes_left == cnt_w'(1)) state <= st_finish;
        end
        default: begin
          // Wait for the final bus write to retire
          if (req.ready) load_done <= 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: wb_byte_writer.sv
/* Wishbone byte write master */
`timescale 1ns/1ps
`default_nettype none

module wb_byte_writer #(
  parameter int ADDR_W = 22
) (
  input  logic              clk,
  input  logic              reset_nes,
  load_req_if.writer        req,
  output logic [ADDR_W-1:0] mem_adr,
  output logic [7:0]        mem_wdata,
  output logic              mem_we,
  output logic              mem_cyc,
  output logic              mem_stb,
  input  logic              mem_ack
);

  typedef enum logic {wr_idle, wr_active} wr_state_e;

  wr_state_e state;

  // Only take a new byte when no cycle is open
  assign req.ready = (state == wr_idle);

  // Classic single write, all strobes together
  assign mem_cyc = (state == wr_active);
  assign mem_stb = (state == wr_active);
  assign mem_we  = (state == wr_active);

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      state <= wr_idle;
    end else begin
      case (state)
        wr_idle:   if (req.valid) state <= wr_active;
        wr_active: if (mem_ack) state <= wr_idle;  // Close cycle on ack
        default:   state <= wr_idle;
      endcase
    end
  end

  // Address and data held stable for the whole cycle
  always_ff @(posedge clk) begin
    if (req.valid && req.ready) begin
      mem_adr   <= req.addr;
      mem_wdata <= req.data;
    end
  end

endmodule

`default_nettype wire

// File: loader_regs.sv
/* Loader host register block */
`timescale 1ns/1ps
`default_nettype none

module loader_regs import nes_loader_pkg::*; (
  input  logic          clk,
  input  logic          reset_nes,
  input  logic [1:0]    host_adr,
  input  logic [31:0]   host_wdata,
  output logic [31:0]   host_rdata,
  input  logic          host_we,
  input  logic          host_cyc,
  input  logic          host_stb,
  output logic          host_ack,
  input  logic          load_done,
  input  logic          load_error,
  input  logic          busy,
  input  mapper_flags_t flags_in,
  output logic          restart,
  output logic          invert_mirroring
);

  logic          access;   // Bus cycle in its first clock
  logic          done_q;   // For load_done edge detect
  mapper_flags_t flags_q;
  mapper_flags_t flags_rd;
  logic [31:0]   status_word;

  assign access = host_cyc && host_stb && !host_ack;

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      host_ack         <= 1'b0;
      restart          <= 1'b0;
      invert_mirroring <= 1'b0;
      done_q           <= 1'b0;
      flags_q          <= '0;
    end else begin
      host_ack <= access;  // Single-cycle ack
      restart  <= 1'b0;
      done_q   <= load_done;
      if (access && host_we && host_adr == reg_ctrl) begin
        invert_mirroring <= host_wdata[ctrl_invert_bit];
        restart          <= host_wdata[ctrl_restart_bit];  // Self-clearing
      end
      if (load_done && !done_q) flags_q <= flags_in;  // Snapshot at load end
    end
  end

  always_comb begin
    status_word                 = '0;
    status_word[stat_done_bit]  = load_done;
    status_word[stat_error_bit] = load_error;
    status_word[stat_busy_bit]  = busy;
    flags_rd                    = flags_q;
    flags_rd.mirroring          = flags_q.mirroring ^ invert_mirroring;
  end

  // Read mux, valid while stb is held up to ack
  always_comb begin
    host_rdata = '0;
    case (host_adr)
      reg_ctrl:   host_rdata[ctrl_invert_bit] = invert_mirroring;
      reg_status: host_rdata = status_word;
      reg_flags:  host_rdata = flags_rd;
      default:    host_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: nes_loader_top.sv
/* NES cartridge loader top */
`timescale 1ns/1ps
`default_nettype none

module nes_loader_top import nes_loader_pkg::*; #(
  parameter int ADDR_W = 22
) (
  input  logic              clk,
  input  logic              reset_nes,
  input  logic [7:0]        in_data,
  input  logic              in_valid,
  output logic              in_ready,
  output logic [ADDR_W-1:0] mem_adr,
  output logic [7:0]        mem_wdata,
  output logic              mem_we,
  output logic              mem_cyc,
  output logic              mem_stb,
  input  logic              mem_ack,
  input  logic [1:0]        host_adr,
  input  logic [31:0]       host_wdata,
  output logic [31:0]       host_rdata,
  input  logic              host_we,
  input  logic              host_cyc,
  input  logic              host_stb,
  output logic              host_ack,
  output logic              done,
  output logic              error
);

  logic          busy;
  logic          restart;   // One-cycle pulse from host
  mapper_flags_t flags;

  load_req_if #(.ADDR_W(ADDR_W)) req_bus ();

  rom_loader #(.ADDR_W(ADDR_W)) u_loader (
    .clk        (clk),
    .reset_nes  (reset_nes),
    .restart    (restart),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .req        (req_bus.loader),
    .load_done  (done),
    .load_error (error),
    .busy       (busy),
    .flags      (flags)
  );

  wb_byte_writer #(.ADDR_W(ADDR_W)) u_writer (
    .clk       (clk),
    .reset_nes (reset_nes),
    .req       (req_bus.writer),
    .mem_adr   (mem_adr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_ack   (mem_ack)
  );

  // Mirroring invert is applied in the flags read path only
  loader_regs u_regs (
    .clk              (clk),
    .reset_nes        (reset_nes),
    .host_adr         (host_adr),
    .host_wdata       (host_wdata),
    .host_rdata       (host_rdata),
    .host_we          (host_we),
    .host_cyc         (host_cyc),
    .host_stb         (host_stb),
    .host_ack         (host_ack),
    .load_done        (done),
    .load_error       (error),
    .busy             (busy),
    .flags_in         (flags),
    .restart          (restart),
    .invert_mirroring ()
  );

endmodule

`default_nettype wire

// File: tb_cart_mem.sv
/* Cartridge memory model */
`timescale 1ns/1ps
`default_nettype none

module tb_cart_mem #(
  parameter int ADDR_W = 22
) (
  input  logic              clk,
  input  logic              reset_nes,
  input  logic [ADDR_W-1:0] adr,
  input  logic [7:0]        wdata,
  input  logic              we,
  input  logic              cyc,
  input  logic              stb,
  input  logic [1:0]        ack_delay,  // Wait states before ack
  output logic              ack,
  output logic              wr_seen,    // One cycle per finished write
  output logic [ADDR_W-1:0] seen_adr,
  output logic [7:0]        seen_data
);

  logic [1:0] wait_cnt;  // Wait states spent so far

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      ack      <= 1'b0;
      wr_seen  <= 1'b0;
      wait_cnt <= '0;
    end else begin
      ack     <= 1'b0;
      wr_seen <= 1'b0;
      // Ignore the cycle where our own ack is still up
      if (cyc && stb && !ack) begin
        if (wait_cnt == ack_delay) begin
          ack       <= 1'b1;
          wr_seen   <= we;
          seen_adr  <= adr;
          seen_data <= wdata;
          wait_cnt  <= '0;
        end else begin
          wait_cnt <= wait_cnt + 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: nes_loader_props.sv
/* Wishbone master bus checks */
`timescale 1ns/1ps
`default_nettype none

module nes_loader_props #(
  parameter int ADDR_W = 22
) (
  input logic              clk,
  input logic              reset_nes,
  input logic              req_valid,
  input logic              req_ready,
  input logic              mem_cyc,
  input logic              mem_stb,
  input logic              mem_ack,
  input logic [ADDR_W-1:0] mem_adr,
  input logic [7:0]        mem_wdata
);

  int   fail_count = 0;  // Read back by the testbench
  logic open_q;          // Request accepted, ack not yet seen

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      open_q <= 1'b0;
    end else if (req_valid && req_ready) begin
      open_q <= 1'b1;
    end else if (mem_stb && mem_ack) begin
      open_q <= 1'b0;  // Cycle retired
    end
  end

  // Strobe only inside a bus cycle for an accepted request
  stb_needs_cyc: assert property (@(posedge clk) disable iff (reset_nes)
    mem_stb |-> mem_cyc && open_q)
    else begin
      $error("mem_stb high outside a bus cycle");
      fail_count++;
    end

  // Write held until the slave acks
  stb_held: assert property (@(posedge clk) disable iff (reset_nes)
    mem_stb && !mem_ack |=> mem_stb && $stable(mem_adr) && $stable(mem_wdata))
    else begin
      $error("mem_stb, mem_adr or mem_wdata moved before ack");
      fail_count++;
    end

  // No second request while one is open
  one_in_flight: assert property (@(posedge clk) disable iff (reset_nes)
    open_q |-> !(req_valid && req_ready))
    else begin
      $error("new request accepted before ack");
      fail_count++;
    end

endmodule

bind wb_byte_writer nes_loader_props #(.ADDR_W(ADDR_W)) u_props (
  .clk       (clk),
  .reset_nes (reset_nes),
  .req_valid (req.valid),
  .req_ready (req.ready),
  .mem_cyc   (mem_cyc),
  .mem_stb   (mem_stb),
  .mem_ack   (mem_ack),
  .mem_adr   (mem_adr),
  .mem_wdata (mem_wdata)
);

`default_nettype wire

// File: tb_nes_loader.sv
/* NES loader testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_nes_loader import nes_loader_pkg::*; ();

  localparam int ADDR_W    = 22;
  localparam int prg_bytes = 1 << prg_page_shift;
  localparam int chr_bytes = 1 << chr_page_shift;
  // Six headers, four PRG pages and two CHR pages over all tests
  localparam int image_bytes = 6 * ines_hdr_len + 4 * prg_bytes + 2 * chr_bytes;
  localparam int cycle_limit = image_bytes * 6 + 2000;  // Slowest ack costs six cycles a byte
  localparam logic [ADDR_W-1:0] chr_base = {1'b1, {(ADDR_W-1){1'b0}}};

  logic              clk = 1'b0;
  logic              reset_nes;
  logic [7:0]        in_data;
  logic              in_valid;
  logic              in_ready;
  logic [ADDR_W-1:0] mem_adr;
  logic [7:0]        mem_wdata;
  logic              mem_we;
  logic              mem_cyc;
  logic              mem_stb;
  logic              mem_ack;
  logic [1:0]        host_adr;
  logic [31:0]       host_wdata;
  logic [31:0]       host_rdata;
  logic              host_we;
  logic              host_cyc;
  logic              host_stb;
  logic              host_ack;
  logic              done;
  logic              error;
  logic [1:0]        ack_delay = 2'd1;
  logic              wr_seen;
  logic [ADDR_W-1:0] seen_adr;
  logic [7:0]        seen_data;

  logic [7:0]        image [$];       // Bytes to stream
  logic [ADDR_W-1:0] exp_adr [$];     // Expected writes
  logic [7:0]        exp_data [$];
  logic [ADDR_W-1:0] log_adr_q [$];   // Writes seen on the bus
  logic [7:0]        log_data_q [$];
  logic [31:0]       pay_seed = 32'd99543;
  logic [31:0]       dly_seed = 32'd99543;
  int                errors = 0;
  int                checks = 0;
  int                prop_fails;
  int                cycles;

  nes_loader_top #(.ADDR_W(ADDR_W)) DUT (
    .clk        (clk),
    .reset_nes  (reset_nes),
    .in_data    (in_data),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .mem_adr    (mem_adr),
    .mem_wdata  (mem_wdata),
    .mem_we     (mem_we),
    .mem_cyc    (mem_cyc),
    .mem_stb    (mem_stb),
    .mem_ack    (mem_ack),
    .host_adr   (host_adr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .host_we    (host_we),
    .host_cyc   (host_cyc),
    .host_stb   (host_stb),
    .host_ack   (host_ack),
    .done       (done),
    .error      (error)
  );

  tb_cart_mem #(.ADDR_W(ADDR_W)) u_mem (
    .clk       (clk),
    .reset_nes (reset_nes),
    .adr       (mem_adr),
    .wdata     (mem_wdata),
    .we        (mem_we),
    .cyc       (mem_cyc),
    .stb       (mem_stb),
    .ack_delay (ack_delay),
    .ack       (mem_ack),
    .wr_seen   (wr_seen),
    .seen_adr  (seen_adr),
    .seen_data (seen_data)
  );

  always #20 clk = ~clk;  // 40 ns period

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Log mid-cycle, new wait states for the next write
  always @(negedge clk) begin
    if (wr_seen) begin
      log_adr_q.push_back(seen_adr);
      log_data_q.push_back(seen_data);
      dly_seed  = lcg_step(dly_seed);
      ack_delay <= dly_seed[17:16];
    end
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the loader stopped making progress", cycle_limit);
    $display("Checks failed");
    $finish;
  end

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic host_access(input logic [1:0] adr, input logic we, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    host_adr   = adr;
    host_we    = we;
    host_wdata = wdata;
    host_cyc   = 1'b1;
    host_stb   = 1'b1;
    @(posedge clk);
    #1;
    while (!host_ack) begin
      @(posedge clk);
      #1;
    end
    rdata    = host_rdata;  // Valid while ack is up
    host_cyc = 1'b0;
    host_stb = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic host_write(input logic [1:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    host_access(adr, 1'b1, wdata, unused);
  endtask

  task automatic host_read(input logic [1:0] adr, output logic [31:0] rdata);
    host_access(adr, 1'b0, 32'd0, rdata);
  endtask

  task automatic restart_loader(input logic invert);
    logic [31:0] ctrl;
    ctrl                   = '0;
    ctrl[ctrl_restart_bit] = 1'b1;
    ctrl[ctrl_invert_bit]  = invert;
    host_write(reg_ctrl, ctrl);
  endtask

  // Header plus LCG payload, expected writes alongside
  task automatic build_image(input logic [7:0] prg, input logic [7:0] chr,
                             input logic [7:0] f6, input logic [7:0] f7, input logic [7:0] b12);
    logic [7:0] b;
    image.delete();
    exp_adr.delete();
    exp_data.delete();
    image.push_back(8'h4E);  // "NES" then 1A
    image.push_back(8'h45);
    image.push_back(8'h53);
    image.push_back(8'h1A);
    image.push_back(prg);
    image.push_back(chr);
    image.push_back(f6);
    image.push_back(f7);
    for (int i = 8; i < ines_hdr_len; i++) begin
      image.push_back((i == 12) ? b12 : 8'h00);
    end
    for (int i = 0; i < int'(prg) * prg_bytes; i++) begin
      pay_seed = lcg_step(pay_seed);
      b        = pay_seed[23:16];
      image.push_back(b);
      exp_adr.push_back(ADDR_W'(i));  // PRG from address zero
      exp_data.push_back(b);
    end
    for (int i = 0; i < int'(chr) * chr_bytes; i++) begin
      pay_seed = lcg_step(pay_seed);
      b        = pay_seed[23:16];
      image.push_back(b);
      exp_adr.push_back(chr_base + ADDR_W'(i));
      exp_data.push_back(b);
    end
  endtask

  // Rejected image ends after its header, nothing gets written
  task automatic keep_header_only();
    while (image.size() > ines_hdr_len) begin
      void'(image.pop_back());
    end
    exp_adr.delete();
    exp_data.delete();
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic taken;
    in_data  = b;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      taken = in_ready;  // Moves only on clock edges
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic stream_and_compare(input string name, input logic exp_err);
    int n;
    log_adr_q.delete();
    log_data_q.delete();
    foreach (image[i]) send_byte(image[i]);
    while (!done) begin
      @(posedge clk);
      #1;
    end
    compare(32'(error), 32'(exp_err), {name, " error output"});
    compare(log_adr_q.size(), exp_adr.size(), {name, " write count"});
    n = (log_adr_q.size() < exp_adr.size()) ? log_adr_q.size() : exp_adr.size();
    for (int i = 0; i < n; i++) begin
      compare(32'(log_adr_q[i]), 32'(exp_adr[i]), {name, " write address"});
      compare(32'(log_data_q[i]), 32'(exp_data[i]), {name, " write data"});
    end
  endtask

  task automatic check_reset_state();
    logic [31:0] rd;
    host_read(reg_status, rd);
    compare(rd, 32'd0, "status after reset");
    host_read(reg_flags, rd);
    compare(rd, 32'd0, "flags after reset");
    compare(32'(in_ready), 32'd1, "in_ready after reset");
  endtask

  task automatic load_prg_only();
    mapper_flags_t ef;
    logic [31:0]   rd;
    build_image(8'd1, 8'd0, 8'h00, 8'h00, 8'h00);
    stream_and_compare("prg only", 1'b0);
    host_read(reg_status, rd);
    compare(rd, 32'h1, "prg only status");  // Done alone
    ef             = '0;
    ef.has_chr_ram = 1'b1;  // Both size codes 0
    host_read(reg_flags, rd);
    compare(rd, ef, "prg only flags");
  endtask

  task automatic load_prg_and_chr();
    mapper_flags_t ef;
    logic [31:0]   rd;
    restart_loader(1'b0);
    build_image(8'd2, 8'd1, 8'hA1, 8'h40, 8'h00);
    stream_and_compare("prg and chr", 1'b0);
    host_read(reg_status, rd);
    compare(rd, 32'h1, "prg and chr status");
    ef           = '0;
    ef.mapper    = 8'h4A;  // High nibble from byte 7
    ef.prg_size  = 3'd1;
    ef.mirroring = 1'b1;
    host_read(reg_flags, rd);
    compare(rd, ef, "prg and chr flags");
  endtask

  task automatic reject_bad_headers();
    mapper_flags_t ef;
    logic [31:0]   rd;
    restart_loader(1'b0);
    build_image(8'd1, 8'd0, 8'h00, 8'h00, 8'h00);
    image[3] = 8'h1B;  // Broken signature
    keep_header_only();
    stream_and_compare("bad magic", 1'b1);
    host_read(reg_status, rd);
    compare(rd, 32'h3, "bad magic status");
    restart_loader(1'b0);
    host_read(reg_status, rd);
    compare(rd, 32'h0, "status after restart");
    build_image(8'd1, 8'd0, 8'h04, 8'h00, 8'h00);  // Trainer bit set
    keep_header_only();
    stream_and_compare("trainer", 1'b1);
    host_read(reg_status, rd);
    compare(rd, 32'h3, "trainer status");
    restart_loader(1'b0);
    host_read(reg_status, rd);
    compare(rd, 32'h0, "status after second restart");
    build_image(8'd1, 8'd0, 8'h10, 8'h20, 8'h00);
    stream_and_compare("reload", 1'b0);
    host_read(reg_status, rd);
    compare(rd, 32'h1, "reload status");
    ef             = '0;
    ef.mapper      = 8'h21;
    ef.has_chr_ram = 1'b1;
    host_read(reg_flags, rd);
    compare(rd, ef, "reload flags");
  endtask

  task automatic decode_dirty_header();
    mapper_flags_t ef;
    logic [31:0]   rd;
    restart_loader(1'b1);
    // No PRG so CHR follows the header directly
    build_image(8'd0, 8'd1, 8'h31, 8'h70, 8'h55);
    stream_and_compare("dirty header", 1'b0);
    host_read(reg_status, rd);
    compare(rd, 32'h1, "dirty header status");
    ef           = '0;
    ef.mapper    = 8'h03;  // Byte 7 nibble dropped
    ef.mirroring = 1'b0;   // Byte 6 bit 0 inverted
    host_read(reg_flags, rd);
    compare(rd, ef, "dirty header flags");
    host_read(reg_ctrl, rd);
    compare(rd, 32'h1, "ctrl invert bit");
  endtask

  initial begin
    reset_nes  = 1'b1;
    in_data    = 8'h00;
    in_valid   = 1'b0;
    host_adr   = 2'd0;
    host_wdata = 32'd0;
    host_we    = 1'b0;
    host_cyc   = 1'b0;
    host_stb   = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset_nes = 1'b0;
    check_reset_state();
    load_prg_only();
    load_prg_and_chr();
    reject_bad_headers();
    decode_dirty_header();
    prop_fails = DUT.u_writer.u_props.fail_count;
    $display("Summary %0d checks, %0d errors, %0d assertion failures",
             checks, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
nes_loader_pkg.sv
load_req_if.sv
ines_header_parser.sv
rom_loader.sv
wb_byte_writer.sv
loader_regs.sv
nes_loader_top.sv
tb_cart_mem.sv
nes_loader_props.sv
tb_nes_loader.sv

// File: Makefile
# Verilator build and run for the NES loader testbench

VERILATOR ?= verilator
TOP       ?= tb_nes_loader
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' vlog.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) vlog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
